/* hdl/buffer_pkg.sv */
`default_nettype none

package buffer_pkg;

  // stream and register data width
  localparam int DATA_W = 8;

  // fifo geometry
  localparam int DEPTH = 32;
  localparam int PTR_W = 5;
  // occupancy runs 0..DEPTH, so one extra bit
  localparam int LEVEL_W = 6;

  localparam int REG_ADDR_W = 3;

  // register map
  typedef enum logic [REG_ADDR_W-1:0] {
    REG_CTRL       = 3'd0,
    REG_FULL_THRE  = 3'd1,
    REG_EMPTY_THRE = 3'd2,
    REG_IDLE_VALUE = 3'd3,
    REG_STATUS     = 3'd4,
    REG_LEVEL      = 3'd5,
    REG_FLAG_CLR   = 3'd6
  } reg_addr_e;

  // values loaded at reset
  localparam logic [LEVEL_W-1:0] FULL_THRE_RST  = 6'd25;
  localparam logic [LEVEL_W-1:0] EMPTY_THRE_RST = 6'd6;
  localparam logic [DATA_W-1:0]  IDLE_VALUE_RST = 8'hFF;

endpackage

`default_nettype wire

/* hdl/fifo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_core
  import buffer_pkg::*;
(
  input  wire logic               CLK,
  input  wire logic               RESETN,
  input  wire logic [DATA_W-1:0]  din,
  input  wire logic               we,
  input  wire logic               re,
  input  wire logic               flush,
  input  wire logic [LEVEL_W-1:0] full_thre,
  input  wire logic [LEVEL_W-1:0] empty_thre,
  input  wire logic [DATA_W-1:0]  idle_value,
  output logic      [DATA_W-1:0]  dout,
  output logic                    not_empty,
  output logic                    full,
  output logic                    prog_full,
  output logic                    prog_empty,
  output logic      [LEVEL_W-1:0] level,
  output logic                    push_drop,
  output logic                    pop_miss
);

  logic [DATA_W-1:0]  mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [LEVEL_W-1:0] count;

  // read burst arming
  logic re_q;
  logic re_rise;
  logic armed;

  logic push;
  logic pop;

  assign re_rise = re && !re_q;

  assign push = we && !full;
  // pops only once a burst has been armed by an earlier rising edge
  assign pop  = armed && re && not_empty;

  // flags straight from the counter
  assign level      = count;
  assign not_empty  = (count != '0);
  assign full       = (count == LEVEL_W'(DEPTH));
  assign prog_full  = (count >= full_thre);
  assign prog_empty = (count <= empty_thre);

  // back-pressure reporting
  assign push_drop = we && full;
  assign pop_miss  = re && !not_empty && (armed || re_rise);

  // head entry only while armed
  assign dout = armed ? mem[rd_ptr] : idle_value;

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      re_q <= 1'b0;
    end else begin
      re_q <= re;
    end
  end

  // a burst ends when re drops or the buffer runs dry
  always_ff @(posedge CLK) begin
    if (!RESETN || flush || !not_empty || !re) begin
      armed <= 1'b0;
    end else if (re_rise) begin
      armed <= 1'b1;
    end
  end

  // pointers and occupancy
  // flush takes priority over traffic
  always_ff @(posedge CLK) begin
    if (!RESETN || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // read side stays put across an empty cycle unless flushed
  a_no_pop_empty: assert property (
    @(posedge CLK) disable iff (!RESETN)
    (!not_empty && !flush) |=> (rd_ptr == $past(rd_ptr))
  );

  // write side stays put while full
  a_no_push_full: assert property (
    @(posedge CLK) disable iff (!RESETN)
    (full && !flush) |=> (wr_ptr == $past(wr_ptr))
  );

  a_level_range: assert property (
    @(posedge CLK) disable iff (!RESETN)
    count <= LEVEL_W'(DEPTH)
  );

endmodule

`default_nettype wire

/* hdl/buffer_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module buffer_regs
  import buffer_pkg::*;
(
  input  wire logic               CLK,
  input  wire logic               RESETN,
  input  wire logic               reg_wr,
  input  wire logic               reg_rd,
  input  wire reg_addr_e          reg_addr,
  input  wire logic [DATA_W-1:0]  reg_wdata,
  input  wire logic [LEVEL_W-1:0] level,
  input  wire logic               not_empty,
  input  wire logic               full,
  input  wire logic               prog_full,
  input  wire logic               prog_empty,
  input  wire logic               push_drop,
  input  wire logic               pop_miss,
  output logic      [DATA_W-1:0]  reg_rdata,
  output logic      [LEVEL_W-1:0] full_thre,
  output logic      [LEVEL_W-1:0] empty_thre,
  output logic      [DATA_W-1:0]  idle_value,
  output logic                    flush
);

  // sticky error flags
  logic overflow;
  logic underflow;
  logic clr_overflow;
  logic clr_underflow;

  logic [DATA_W-1:0] status;
  logic [DATA_W-1:0] rd_mux;

  assign clr_overflow  = reg_wr && (reg_addr == REG_FLAG_CLR) && reg_wdata[4];
  assign clr_underflow = reg_wr && (reg_addr == REG_FLAG_CLR) && reg_wdata[5];

  assign status = {2'b00, underflow, overflow, prog_empty, prog_full, full, not_empty};

  // configuration writes and flush pulse
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      full_thre  <= FULL_THRE_RST;
      empty_thre <= EMPTY_THRE_RST;
      idle_value <= IDLE_VALUE_RST;
      flush      <= 1'b0;
    end else begin
      flush <= 1'b0;
      if (reg_wr) begin
        case (reg_addr)
          REG_CTRL: begin
            flush <= reg_wdata[0];
          end
          REG_FULL_THRE: begin
            full_thre <= reg_wdata[LEVEL_W-1:0];
          end
          REG_EMPTY_THRE: begin
            empty_thre <= reg_wdata[LEVEL_W-1:0];
          end
          REG_IDLE_VALUE: begin
            idle_value <= reg_wdata;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // a new event in the same cycle beats the clear
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else begin
      overflow  <= push_drop || (overflow && !clr_overflow);
      underflow <= pop_miss || (underflow && !clr_underflow);
    end
  end

  // readback select
  always_comb begin
    case (reg_addr)
      REG_FULL_THRE:  rd_mux = DATA_W'(full_thre);
      REG_EMPTY_THRE: rd_mux = DATA_W'(empty_thre);
      REG_IDLE_VALUE: rd_mux = idle_value;
      REG_STATUS:     rd_mux = status;
      REG_LEVEL:      rd_mux = DATA_W'(level);
      default:        rd_mux = '0;
    endcase
  end

  // held until the next read strobe
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      reg_rdata <= '0;
    end else if (reg_rd) begin
      reg_rdata <= rd_mux;
    end
  end

  a_strobes_exclusive: assert property (
    @(posedge CLK) disable iff (!RESETN)
    !(reg_wr && reg_rd)
  );

  // flush is a single cycle pulse
  a_flush_pulse: assert property (
    @(posedge CLK) disable iff (!RESETN)
    flush |=> !flush
  );

endmodule

`default_nettype wire

/* hdl/stream_buffer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_buffer_top
  import buffer_pkg::*;
(
  input  wire logic              CLK,
  input  wire logic              RESETN,
  input  wire logic [DATA_W-1:0] din,
  input  wire logic              we,
  output logic      [DATA_W-1:0] dout,
  input  wire logic              re,
  output logic                   not_empty,
  output logic                   full,
  output logic                   prog_full,
  output logic                   prog_empty,
  input  wire logic              reg_wr,
  input  wire logic              reg_rd,
  input  wire reg_addr_e         reg_addr,
  input  wire logic [DATA_W-1:0] reg_wdata,
  output logic      [DATA_W-1:0] reg_rdata
);

  // register block to core
  logic [LEVEL_W-1:0] full_thre;
  logic [LEVEL_W-1:0] empty_thre;
  logic [DATA_W-1:0]  idle_value;
  logic               flush;

  // core to register block
  logic [LEVEL_W-1:0] level;
  logic               push_drop;
  logic               pop_miss;

  buffer_regs u_regs (
    .CLK        (CLK),
    .RESETN     (RESETN),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .level      (level),
    .not_empty  (not_empty),
    .full       (full),
    .prog_full  (prog_full),
    .prog_empty (prog_empty),
    .push_drop  (push_drop),
    .pop_miss   (pop_miss),
    .reg_rdata  (reg_rdata),
    .full_thre  (full_thre),
    .empty_thre (empty_thre),
    .idle_value (idle_value),
    .flush      (flush)
  );

  fifo_core u_fifo (
    .CLK        (CLK),
    .RESETN     (RESETN),
    .din        (din),
    .we         (we),
    .re         (re),
    .flush      (flush),
    .full_thre  (full_thre),
    .empty_thre (empty_thre),
    .idle_value (idle_value),
    .dout       (dout),
    .not_empty  (not_empty),
    .full       (full),
    .prog_full  (prog_full),
    .prog_empty (prog_empty),
    .level      (level),
    .push_drop  (push_drop),
    .pop_miss   (pop_miss)
  );

endmodule

`default_nettype wire

/* testbench/stream_buffer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_buffer_tb
  import buffer_pkg::*;
;

  // rough cycle budget per test, doubled for the watchdog
  localparam int TEST_CYCLES = 20 + 100 + 80 + 120 + 60 + 400;
  localparam int WATCHDOG_NS = 2 * TEST_CYCLES * 8;

  logic              CLK;
  logic              RESETN;
  logic [DATA_W-1:0] din;
  logic              we;
  logic [DATA_W-1:0] dout;
  logic              re;
  logic              not_empty;
  logic              full;
  logic              prog_full;
  logic              prog_empty;
  logic              reg_wr;
  logic              reg_rd;
  reg_addr_e         reg_addr;
  logic [DATA_W-1:0] reg_wdata;
  logic [DATA_W-1:0] reg_rdata;

  // expected contents and register state
  logic [DATA_W-1:0] model[$];
  int                exp_full_thre = 25;
  int                exp_empty_thre = 6;
  logic [DATA_W-1:0] exp_idle = 8'hFF;
  logic              exp_ovf = 1'b0;
  logic              exp_unf = 1'b0;
  int                seed = 32'h1ee;
  int                errors = 0;

  stream_buffer_top uut (
    .CLK        (CLK),
    .RESETN     (RESETN),
    .din        (din),
    .we         (we),
    .dout       (dout),
    .re         (re),
    .not_empty  (not_empty),
    .full       (full),
    .prog_full  (prog_full),
    .prog_empty (prog_empty),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata)
  );

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  function automatic logic [7:0] exp_status();
    int n;
    n = model.size();
    return {2'b00, exp_unf, exp_ovf, n <= exp_empty_thre, n >= exp_full_thre,
            n == DEPTH, n != 0};
  endfunction

  // status pins against the queue model
  task automatic check_flags();
    #1;
    check_val("not_empty", not_empty, model.size() != 0);
    check_val("full", full, model.size() == DEPTH);
    check_val("prog_full", prog_full, model.size() >= exp_full_thre);
    check_val("prog_empty", prog_empty, model.size() <= exp_empty_thre);
  endtask

  task automatic do_push(input logic [7:0] data);
    @(posedge CLK);
    #1;
    we = 1'b1;
    din = data;
    @(posedge CLK);
    #1;
    we = 1'b0;
    if (model.size() < DEPTH) begin
      model.push_back(data);
    end else begin
      exp_ovf = 1'b1;
    end
    check_flags();
  endtask

  // one lead-in cycle, then one byte per cycle
  task automatic do_read_burst(input int n, input bit hold);
    @(posedge CLK);
    #1;
    re = 1'b1;
    #1;
    check_val("dout", dout, exp_idle);
    for (int i = 0; i < n; i++) begin
      @(posedge CLK);
      #2;
      check_val("dout", dout, model.pop_front());
    end
    @(posedge CLK);
    #1;
    if (hold && model.size() == 0) begin
      exp_unf = 1'b1;
      @(posedge CLK);
      #1;
    end
    re = 1'b0;
    check_flags();
    if (model.size() == 0) begin
      @(posedge CLK);
      #2;
      check_val("dout", dout, exp_idle);
    end
  endtask

  task automatic reg_write(input reg_addr_e addr, input logic [7:0] data);
    @(posedge CLK);
    #1;
    reg_wr = 1'b1;
    reg_addr = addr;
    reg_wdata = data;
    @(posedge CLK);
    #1;
    reg_wr = 1'b0;
  endtask

  task automatic reg_read(input reg_addr_e addr, input logic [7:0] exp, input string name);
    @(posedge CLK);
    #1;
    reg_rd = 1'b1;
    reg_addr = addr;
    @(posedge CLK);
    #1;
    reg_rd = 1'b0;
    check_val(name, reg_rdata, exp);
  endtask

  task automatic test_reset();
    check_val("reg_rdata", reg_rdata, 0);
    check_val("dout", dout, 8'hFF);
    check_flags();
    reg_read(REG_FULL_THRE, 8'd25, "full_thre");
    reg_read(REG_EMPTY_THRE, 8'd6, "empty_thre");
    reg_read(REG_IDLE_VALUE, 8'hFF, "idle_value");
    reg_read(REG_STATUS, 8'h08, "status");
    reg_read(REG_LEVEL, 8'd0, "level");
  endtask

  task automatic test_fill();
    for (int i = 0; i < DEPTH; i++) begin
      do_push(8'($random(seed)));
    end
    reg_read(REG_LEVEL, 8'd32, "level");
    // one more push is dropped
    do_push(8'($random(seed)));
    reg_read(REG_STATUS, exp_status(), "status");
    reg_write(REG_FLAG_CLR, 8'h10);
    exp_ovf = 1'b0;
    reg_read(REG_STATUS, exp_status(), "status");
    reg_read(REG_LEVEL, 8'd32, "level");
  endtask

  task automatic test_bursts();
    do_read_burst(10, 1'b0);
    reg_write(REG_IDLE_VALUE, 8'h5A);
    exp_idle = 8'h5A;
    do_read_burst(model.size(), 1'b1);
    reg_read(REG_STATUS, exp_status(), "status");
    reg_write(REG_FLAG_CLR, 8'h20);
    exp_unf = 1'b0;
    reg_read(REG_STATUS, exp_status(), "status");
  endtask

  task automatic test_thresholds();
    reg_write(REG_FULL_THRE, 8'd10);
    reg_write(REG_EMPTY_THRE, 8'd3);
    exp_full_thre = 10;
    exp_empty_thre = 3;
    for (int i = 0; i < 12; i++) begin
      do_push(8'($random(seed)));
    end
    // single-byte bursts, flags checked after each pop
    while (model.size() > 0) begin
      do_read_burst(1, 1'b0);
    end
  endtask

  task automatic test_flush();
    for (int i = 0; i < 5; i++) begin
      do_push(8'($random(seed)));
    end
    reg_write(REG_CTRL, 8'h01);
    model.delete();
    @(posedge CLK);
    #1;
    check_flags();
    reg_read(REG_LEVEL, 8'd0, "level");
    for (int i = 0; i < 4; i++) begin
      do_push(8'($random(seed)));
    end
    do_read_burst(4, 1'b0);
  endtask

  task automatic test_mixed();
    int n;
    int m;
    for (int r = 0; r < 10; r++) begin
      n = ($random(seed) & 7) + 1;
      for (int i = 0; i < n && model.size() < DEPTH; i++) begin
        do_push(8'($random(seed)));
      end
      m = $random(seed) & 15;
      if (m > model.size()) begin
        m = model.size();
      end
      if (m > 0) begin
        do_read_burst(m, 1'b0);
      end
    end
    if (model.size() > 0) begin
      do_read_burst(model.size(), 1'b0);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    RESETN = 1'b0;
    din = '0;
    we = 1'b0;
    re = 1'b0;
    reg_wr = 1'b0;
    reg_rd = 1'b0;
    reg_addr = REG_CTRL;
    reg_wdata = '0;
    repeat (3) @(posedge CLK);
    #1;
    RESETN = 1'b1;
    test_reset();
    test_fill();
    test_bursts();
    test_thresholds();
    test_flush();
    test_mixed();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* stream_buffer.f */
hdl/buffer_pkg.sv
hdl/fifo_core.sv
hdl/buffer_regs.sv
hdl/stream_buffer_top.sv
testbench/stream_buffer_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the stream buffer testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f stream_buffer.f --top-module stream_buffer_tb -o sim_stream_buffer
./obj_dir/sim_stream_buffer | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"
